//--- include/i2s_defines.svh
//////////////////////////////////////////////////////////////////////
// I2S link constants
// Frame format and register reset values shared by the design
//////////////////////////////////////////////////////////////////////
`ifndef I2S_DEFINES_SVH
`define I2S_DEFINES_SVH

// Bits per audio sample, MSB first on the wire
`define I2S_SAMPLE_W 16

// BCLK periods per channel slot
`define I2S_SLOT_BITS 32

`define I2S_DIV_W 8           // Width of the BCLK divider field

`define I2S_RESET_BCLK_DIV 4  // BCLK half-period after reset, in clk_i cycles

`endif

//--- verilog/i2s_audio_pkg.sv
//////////////////////////////////////////////////////////////////////
// I2S audio types
// Stereo sample layout, the I2S wire bundle and slot naming
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "i2s_defines.svh"

package i2s_audio_pkg;

  typedef struct packed {
    logic [`I2S_SAMPLE_W-1:0] left;
    logic [`I2S_SAMPLE_W-1:0] right;
  } stereo_sample_t;

  typedef struct packed {
    logic mclk;
    logic bclk;
    logic lrclk;      // Low selects the left slot
    logic dac_sdata;  // Master to codec
    logic adc_sdata;  // Codec to master
  } i2s_bus_t;

  typedef enum logic {CH_LEFT = 1'b0, CH_RIGHT = 1'b1} i2s_channel_e;

endpackage

`default_nettype wire

//--- verilog/i2s_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// I2S configuration types
// Register addresses and the settings word fed to the link
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "i2s_defines.svh"

package i2s_cfg_pkg;

  // Register map
  typedef enum logic {
    ADDR_CTRL     = 1'b0,  // Bit 0 is enable
    ADDR_BCLK_DIV = 1'b1   // BCLK half-period in clk_i cycles
  } cfg_addr_e;

  typedef struct packed {
    logic                  enable;
    logic [`I2S_DIV_W-1:0] bclk_div;
  } i2s_cfg_t;

endpackage

`default_nettype wire

//--- verilog/i2s_cfg_regs.sv
//////////////////////////////////////////////////////////////////////
// I2S configuration registers
// Enable and BCLK divider with write strobe and readback
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "i2s_defines.svh"

module i2s_cfg_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_we,
  input  i2s_cfg_pkg::cfg_addr_e cfg_addr,
  input  logic [7:0]            cfg_wdata,
  output logic [7:0]            cfg_rdata,
  output i2s_cfg_pkg::i2s_cfg_t cfg
);

  logic                  enable_q;
  logic [`I2S_DIV_W-1:0] bclk_div_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q   <= 1'b0;
      bclk_div_q <= `I2S_RESET_BCLK_DIV;
    end else if (cfg_we) begin
      case (cfg_addr)
        i2s_cfg_pkg::ADDR_CTRL: begin
          enable_q <= cfg_wdata[0];
        end
        i2s_cfg_pkg::ADDR_BCLK_DIV: begin
          // A half-period under 2 cycles would break the codec edge timing
          bclk_div_q <= (cfg_wdata < 8'd2) ? 8'd2 : cfg_wdata;
        end
        default: ;
      endcase
    end
  end

  // Readback follows the address without a register stage
  always_comb begin
    case (cfg_addr)
      i2s_cfg_pkg::ADDR_CTRL:     cfg_rdata = {7'd0, enable_q};
      i2s_cfg_pkg::ADDR_BCLK_DIV: cfg_rdata = bclk_div_q;
      default:                    cfg_rdata = '0;
    endcase
  end

  assign cfg = '{enable: enable_q, bclk_div: bclk_div_q};

  a_div_min: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bclk_div_q >= 8'd2)
    else $error("bclk_div below 2");

endmodule

`default_nettype wire

//--- verilog/i2s_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// I2S clock generator
// Derives MCLK, BCLK and LRCLK from clk_i with bit and frame strobes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "i2s_defines.svh"

module i2s_clock_gen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  i2s_cfg_pkg::i2s_cfg_t cfg,
  output logic                  mclk,
  output logic                  bclk,
  output logic                  lrclk,
  output logic                  bit_rise,
  output logic                  bit_fall,
  output logic                  frame_start,
  output logic                  half_start
);

  logic [`I2S_DIV_W-1:0] half_cnt;
  logic [`I2S_DIV_W-1:0] div_q;     // Divider in use, reloaded at half-period ends
  logic [5:0]            bit_cnt;   // BCLK falls within the frame
  logic                  run_q;
  logic                  half_end;

  assign half_end = (half_cnt >= div_q - 8'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {mclk, bclk, lrclk, run_q} <= '0;
      {bit_rise, bit_fall, frame_start, half_start} <= '0;
      half_cnt <= '0;
      div_q    <= '0;
      bit_cnt  <= '0;
    end else if (!cfg.enable) begin
      {mclk, bclk, lrclk, run_q} <= '0;
      {bit_rise, bit_fall, frame_start, half_start} <= '0;
      half_cnt <= '0;
      div_q    <= cfg.bclk_div;
      bit_cnt  <= '0;
    end else begin
      mclk        <= ~mclk;
      run_q       <= 1'b1;
      bit_rise    <= 1'b0;
      bit_fall    <= 1'b0;
      half_start  <= 1'b0;
      frame_start <= !run_q;  // Enable rising opens a left slot
      if (half_end) begin
        half_cnt <= '0;
        div_q    <= cfg.bclk_div;
        bclk     <= ~bclk;
        if (!bclk) begin
          bit_rise <= 1'b1;
        end else begin
          bit_fall <= 1'b1;
          bit_cnt  <= bit_cnt + 6'd1;
          if (bit_cnt[4:0] == 5'(`I2S_SLOT_BITS - 1)) begin
            lrclk <= ~lrclk;             // Slot ends on this fall
            frame_start <= bit_cnt[5];   // End of right slot
            half_start  <= !bit_cnt[5];
          end
        end
      end else begin
        half_cnt <= half_cnt + 8'd1;
      end
    end
  end

  // Frame start is the LRCLK fall and half start the LRCLK rise
  a_one_slot_edge: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(frame_start && half_start) && !(frame_start && lrclk) && !(half_start && !lrclk))
    else $error("slot strobes out of step with lrclk");

endmodule

`default_nettype wire

//--- verilog/i2s_handler.sv
//////////////////////////////////////////////////////////////////////
// I2S master data path
// Serializes playback samples and gathers capture samples per frame
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "i2s_defines.svh"

module i2s_handler (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  i2s_cfg_pkg::i2s_cfg_t         cfg,
  input  logic                          bit_rise,
  input  logic                          bit_fall,
  input  logic                          frame_start,
  input  logic                          half_start,
  input  logic                          lrclk,
  input  i2s_audio_pkg::stereo_sample_t dac_sample,
  output logic                          dac_req,
  output logic                          dac_sdata,
  input  logic                          adc_sdata,
  output i2s_audio_pkg::stereo_sample_t adc_sample,
  output logic                          adc_valid
);

  logic [`I2S_SAMPLE_W-1:0]      dac_right;  // Right playback word of this frame
  i2s_audio_pkg::stereo_sample_t rx_hold;    // Capture words until frame end
  i2s_audio_pkg::i2s_channel_e   slot_ch;
  logic [`I2S_SAMPLE_W:0]        tx_sh;
  logic [`I2S_SAMPLE_W-1:0]      rx_sh;
  logic [`I2S_SAMPLE_W-1:0]      rx_word;
  logic [4:0]                    rise_cnt;   // BCLK rises since the LRCLK edge
  logic                          rx_shift;
  logic                          rx_last;
  logic                          right_done;

  assign slot_ch   = i2s_audio_pkg::i2s_channel_e'(lrclk);
  assign dac_sdata = tx_sh[`I2S_SAMPLE_W];
  assign rx_word   = {rx_sh[`I2S_SAMPLE_W-2:0], adc_sdata};

  // Rises 2 to 17 carry the word, rise 1 is the delay bit
  assign rx_shift = bit_rise && (rise_cnt >= 5'd1) && (rise_cnt <= 5'(`I2S_SAMPLE_W));
  assign rx_last  = bit_rise && (rise_cnt == 5'(`I2S_SAMPLE_W));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_sh   <= '0;
      dac_req <= 1'b0;
    end else if (!cfg.enable) begin
      tx_sh   <= '0;
      dac_req <= 1'b0;
    end else begin
      dac_req <= frame_start;
      if (frame_start) begin
        tx_sh <= {1'b0, dac_sample.left};  // Zero bit fills the one-BCLK delay
      end else if (half_start) begin
        tx_sh <= {1'b0, dac_right};
      end else if (bit_fall) begin
        tx_sh <= {tx_sh[`I2S_SAMPLE_W-1:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rise_cnt   <= '0;
      right_done <= 1'b0;
      adc_valid  <= 1'b0;
    end else if (!cfg.enable) begin
      rise_cnt   <= '0;
      right_done <= 1'b0;
      adc_valid  <= 1'b0;
    end else begin
      adc_valid <= frame_start && right_done;
      if (frame_start || half_start) begin
        rise_cnt <= '0;
      end else if (bit_rise) begin
        rise_cnt <= rise_cnt + 5'd1;
      end
      if (frame_start) begin
        right_done <= 1'b0;
      end else if (rx_last && slot_ch == i2s_audio_pkg::CH_RIGHT) begin
        right_done <= 1'b1;  // Full right word in hand
      end
    end
  end

  // Sample payload
  always_ff @(posedge clk_i) begin
    if (frame_start) begin
      dac_right  <= dac_sample.right;
      adc_sample <= rx_hold;
    end
    if (rx_shift) begin
      rx_sh <= rx_word;
    end
    if (rx_last) begin
      if (slot_ch == i2s_audio_pkg::CH_LEFT) rx_hold.left <= rx_word;
      else rx_hold.right <= rx_word;
    end
  end

  // Strobes trace back two cycles to an enabled clock generator
  a_quiet_when_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dac_req || adc_valid) |-> $past(cfg.enable, 2))
    else $error("handler strobe while disabled");

endmodule

`default_nettype wire

//--- verilog/i2s_codec_model.sv
//////////////////////////////////////////////////////////////////////
// I2S codec stand-in
// Recovers bit and frame edges from the I2S clocks and loops test words
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "i2s_defines.svh"

module i2s_codec_model (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          mclk,
  input  logic                          bclk,
  input  logic                          lrclk,
  input  logic                          dac_sdata,
  output logic                          adc_sdata,
  input  i2s_audio_pkg::stereo_sample_t test_in,
  output i2s_audio_pkg::stereo_sample_t test_out
);

  logic                     mclk_last;
  logic                     bclk_last;
  logic                     lrclk_last;
  logic                     running;     // MCLK seen toggling
  logic                     bclk_rise;
  logic                     bclk_fall;
  logic                     lr_rise;
  logic                     lr_fall;
  logic [4:0]               rise_cnt;
  logic [`I2S_SAMPLE_W-1:0] rx_sh;
  logic [`I2S_SAMPLE_W:0]   out_sh;
  i2s_audio_pkg::i2s_channel_e slot_ch;

  assign slot_ch   = i2s_audio_pkg::i2s_channel_e'(lrclk_last);
  assign adc_sdata = out_sh[`I2S_SAMPLE_W];

  // Edges show up one cycle after the clock is sampled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {mclk_last, bclk_last, lrclk_last, running} <= '0;
      {bclk_rise, bclk_fall, lr_rise, lr_fall} <= '0;
    end else begin
      mclk_last  <= mclk;
      bclk_last  <= bclk;
      lrclk_last <= lrclk;
      running    <= (mclk != mclk_last);
      bclk_rise  <= !bclk_last && bclk;
      bclk_fall  <= bclk_last && !bclk;
      lr_rise    <= !lrclk_last && lrclk;
      lr_fall    <= lrclk_last && !lrclk;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rise_cnt <= '0;
      test_out <= '0;
    end else if (!running || lr_rise || lr_fall) begin
      rise_cnt <= '0;
    end else if (bclk_rise) begin
      rise_cnt <= rise_cnt + 5'd1;
      if (rise_cnt > 5'(`I2S_SAMPLE_W)) begin
        if (slot_ch == i2s_audio_pkg::CH_LEFT) test_out.left <= rx_sh;
        else test_out.right <= rx_sh;
      end
    end
  end

  // Capture shift, bits 1 to 16 after the edge
  always_ff @(posedge clk_i) begin
    if (running && !lr_rise && !lr_fall && bclk_rise &&
        rise_cnt >= 5'd1 && rise_cnt <= 5'(`I2S_SAMPLE_W)) begin
      rx_sh <= {rx_sh[`I2S_SAMPLE_W-2:0], dac_sdata};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_sh <= '0;
    end else if (!running || lr_fall) begin
      out_sh <= {1'b0, test_in.left};   // Idle clocks mean a left slot comes first
    end else if (lr_rise) begin
      out_sh <= {1'b0, test_in.right};
    end else if (bclk_fall) begin
      out_sh <= {out_sh[`I2S_SAMPLE_W-1:0], 1'b0};
    end
  end

  // A one-cycle BCLK low phase would let adc_sdata miss the master's sampling
  a_bclk_edges: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bclk_fall |=> !bclk_rise)
    else $error("BCLK rise detected right after a fall");

endmodule

`default_nettype wire

//--- verilog/i2s_loopback_top.sv
//////////////////////////////////////////////////////////////////////
// I2S loopback top
// Register block, clocks, master data path and codec on shared wires
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module i2s_loopback_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cfg_we,
  input  i2s_cfg_pkg::cfg_addr_e        cfg_addr,
  input  logic [7:0]                    cfg_wdata,
  output logic [7:0]                    cfg_rdata,
  input  i2s_audio_pkg::stereo_sample_t dac_sample,
  output logic                          dac_req,
  output i2s_audio_pkg::stereo_sample_t adc_sample,
  output logic                          adc_valid,
  input  i2s_audio_pkg::stereo_sample_t test_in,
  output i2s_audio_pkg::stereo_sample_t test_out,
  output i2s_audio_pkg::i2s_bus_t       i2s
);

  i2s_cfg_pkg::i2s_cfg_t cfg;
  logic mclk, bclk, lrclk, dac_sdata, adc_sdata;
  logic bit_rise, bit_fall, frame_start, half_start;

  i2s_cfg_regs u_regs (.clk_i, .rst_ni, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata, .cfg);

  i2s_clock_gen u_clk_gen (.clk_i, .rst_ni, .cfg, .mclk, .bclk, .lrclk,
                           .bit_rise, .bit_fall, .frame_start, .half_start);

  i2s_handler u_handler (.clk_i, .rst_ni, .cfg, .bit_rise, .bit_fall, .frame_start,
                         .half_start, .lrclk, .dac_sample, .dac_req, .dac_sdata,
                         .adc_sdata, .adc_sample, .adc_valid);

  i2s_codec_model u_codec (.clk_i, .rst_ni, .mclk, .bclk, .lrclk, .dac_sdata,
                           .adc_sdata, .test_in, .test_out);

  // Wire bundle for monitoring
  assign i2s = '{mclk: mclk, bclk: bclk, lrclk: lrclk,
                 dac_sdata: dac_sdata, adc_sdata: adc_sdata};

endmodule

`default_nettype wire

//--- dv/tb_i2s_loopback.sv
//////////////////////////////////////////////////////////////////////
// I2S loopback testbench
// Register, clock, playback, capture and disable checks on the link
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "i2s_defines.svh"

module tb_i2s_loopback;

  localparam int MAX_DIV = 6;                         // Largest divider used while running
  localparam int FRAME_PER_DIV = 4 * `I2S_SLOT_BITS;  // clk_i cycles per frame per divider step

  logic                          clk_i;
  logic                          rst_ni;
  logic                          cfg_we;
  i2s_cfg_pkg::cfg_addr_e        cfg_addr;
  logic [7:0]                    cfg_wdata;
  logic [7:0]                    cfg_rdata;
  i2s_audio_pkg::stereo_sample_t dac_sample;
  logic                          dac_req;
  i2s_audio_pkg::stereo_sample_t adc_sample;
  logic                          adc_valid;
  i2s_audio_pkg::stereo_sample_t test_in;
  i2s_audio_pkg::stereo_sample_t test_out;
  i2s_audio_pkg::i2s_bus_t       i2s;

  int          err_cnt;
  int          timeout_cnt;
  logic [31:0] rng_state;

  i2s_loopback_top i2s_loopback_top_inst (
    .clk_i, .rst_ni, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .dac_sample, .dac_req, .adc_sample, .adc_valid, .test_in, .test_out, .i2s
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic log_error(input string msg);
    err_cnt++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic log_timeout(input string what, input int cycles);
    timeout_cnt++;
    $display("Timed out after %0d cycles waiting for %s", cycles, what);
  endtask

  task automatic write_reg(input i2s_cfg_pkg::cfg_addr_e addr, input logic [7:0] data);
    @(posedge clk_i);
    #1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk_i);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic expect_reg(input i2s_cfg_pkg::cfg_addr_e addr, input logic [7:0] expected);
    @(posedge clk_i);
    #1;
    cfg_addr = addr;
    @(negedge clk_i);  // Readback is combinational on the address
    a_readback: assert (cfg_rdata == expected)
      else log_error($sformatf("reg %0d reads %0d, expected %0d", addr, cfg_rdata, expected));
  endtask

  // Divider writes below 2 read back as 2
  task automatic write_div(input logic [7:0] div);
    write_reg(i2s_cfg_pkg::ADDR_BCLK_DIV, div);
    expect_reg(i2s_cfg_pkg::ADDR_BCLK_DIV, (div < 8'd2) ? 8'd2 : div);
  endtask

  task automatic wait_strobe(input bit on_adc);
    int limit;
    int n;
    bit seen;
    limit = 3 * FRAME_PER_DIV * MAX_DIV + 20;
    seen  = 1'b0;
    for (n = 0; n < limit && !seen; n++) begin
      @(negedge clk_i);
      seen = on_adc ? adc_valid : dac_req;
    end
    if (!seen) log_timeout(on_adc ? "adc_valid" : "dac_req", limit);
  endtask

  // BCLK phase lengths and BCLK rises per LRCLK phase
  task automatic measure_clocks(input int div);
    logic b_prev;
    logic l_prev;
    bit   b_sync;
    bit   l_sync;
    int   b_len;
    int   rises;
    int   lr_phases;
    int   limit;
    int   n;
    limit = 3 * FRAME_PER_DIV * div + 20;
    @(negedge clk_i);
    b_prev    = i2s.bclk;
    l_prev    = i2s.lrclk;
    b_sync    = 1'b0;
    l_sync    = 1'b0;
    b_len     = 0;
    rises     = 0;
    lr_phases = 0;
    for (n = 0; n < limit && lr_phases < 2; n++) begin
      @(negedge clk_i);
      if (i2s.bclk != b_prev) begin
        if (b_sync) begin  // First partial phase is skipped
          a_bclk_phase: assert (b_len == div)
            else log_error($sformatf("bclk phase of %0d cycles, expected %0d", b_len, div));
        end
        b_sync = 1'b1;
        b_len  = 1;
        b_prev = i2s.bclk;
        if (i2s.bclk) rises++;
      end else begin
        b_len++;
      end
      if (i2s.lrclk != l_prev) begin
        if (l_sync) begin
          a_lr_phase: assert (rises == `I2S_SLOT_BITS)
            else log_error($sformatf("lrclk phase with %0d bclk rises", rises));
          lr_phases++;
        end
        l_sync = 1'b1;
        rises  = 0;
        l_prev = i2s.lrclk;
      end
    end
    if (lr_phases < 2) log_timeout("two LRCLK phases", limit);
  endtask

  task automatic run_playback();
    i2s_audio_pkg::stereo_sample_t s;
    wait_strobe(1'b0);
    s = next_random();
    @(posedge clk_i);
    #1;
    dac_sample = s;
    repeat (3) wait_strobe(1'b0);  // Taken at the first pulse, two frames follow
    a_playback: assert (test_out == s)
      else log_error($sformatf("test_out %h, expected %h", test_out, s));
  endtask

  task automatic run_capture();
    i2s_audio_pkg::stereo_sample_t s;
    wait_strobe(1'b1);
    s = next_random();
    @(posedge clk_i);
    #1;
    test_in = s;
    repeat (2) wait_strobe(1'b1);
    a_capture: assert (adc_sample == s)
      else log_error($sformatf("adc_sample %h, expected %h", adc_sample, s));
  endtask

  task automatic watch_idle(input int cycles);
    int n;
    bit active;
    active = 1'b0;
    repeat (3) @(negedge clk_i);  // Enable reaches the clock generator
    for (n = 0; n < cycles; n++) begin
      @(negedge clk_i);
      if (i2s.mclk || i2s.bclk || i2s.lrclk || dac_req || adc_valid) active = 1'b1;
    end
    a_idle: assert (!active) else log_error("link active while disabled");
  endtask

  initial begin
    int div;
    int new_div;
    rst_ni      = 1'b0;
    cfg_we      = 1'b0;
    cfg_addr    = i2s_cfg_pkg::ADDR_CTRL;
    cfg_wdata   = 8'd0;
    dac_sample  = '0;
    test_in     = '0;
    err_cnt     = 0;
    timeout_cnt = 0;
    rng_state   = 32'd35176;
    div         = `I2S_RESET_BCLK_DIV;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    a_reset_idle: assert (i2s == '0 && !dac_req && !adc_valid)
      else log_error("outputs not idle after reset");
    expect_reg(i2s_cfg_pkg::ADDR_CTRL, 8'd0);
    expect_reg(i2s_cfg_pkg::ADDR_BCLK_DIV, 8'(`I2S_RESET_BCLK_DIV));
    write_div(8'd0);
    write_div(8'd1);
    write_div(8'(next_random()));
    write_div(8'(div));
    write_reg(i2s_cfg_pkg::ADDR_CTRL, 8'd1);
    expect_reg(i2s_cfg_pkg::ADDR_CTRL, 8'd1);
    measure_clocks(div);
    run_playback();
    run_capture();
    // New divider while the link runs
    new_div = 2 + int'(next_random() % 32'd5);
    if (new_div == div) new_div = (new_div == MAX_DIV) ? 2 : new_div + 1;
    div = new_div;
    write_div(8'(div));
    measure_clocks(div);
    run_playback();
    run_capture();
    write_reg(i2s_cfg_pkg::ADDR_CTRL, 8'd0);
    expect_reg(i2s_cfg_pkg::ADDR_CTRL, 8'd0);
    watch_idle(3 * FRAME_PER_DIV * MAX_DIV);
    $display("Run complete with %0d errors and %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
verilog/i2s_audio_pkg.sv
verilog/i2s_cfg_pkg.sv
verilog/i2s_cfg_regs.sv
verilog/i2s_clock_gen.sv
verilog/i2s_handler.sv
verilog/i2s_codec_model.sv
verilog/i2s_loopback_top.sv
dv/tb_i2s_loopback.sv

//--- Makefile
# Verilator build and run for the I2S loopback testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run tb_i2s_loopback, pass if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module tb_i2s_loopback \
		-Mdir obj_dir -o sim
	./obj_dir/sim 2>&1 | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
